//--- dv/tb_wb_interconnect.sv
// Wishbone interconnect testbench
`timescale 1ns/1ps
`default_nettype none

module tb_wb_interconnect;

   import wb_pkg::*;

   localparam logic [31:0] SEED        = 32'h8a2f4055;
   localparam int          RST_CYCLES  = 16;
   localparam int          ACK_TIMEOUT = 40;
   localparam int          NUM_RAND    = 200;
   localparam int          HALF_WORDS  = SRAM_DEPTH / 2;

   logic                 clk_i;
   logic                 rst_n;
   wb_req_t              req [NUM_MASTERS];
   wb_rsp_t              rsp [NUM_MASTERS];
   // Reference memory and per-master expectation
   logic [WB_DATA_W-1:0] model_mem [SRAM_DEPTH];
   wb_rsp_t              exp_rsp [NUM_MASTERS];
   logic                 pending [NUM_MASTERS];
   int                   done_cyc [NUM_MASTERS];
   int                   cyc_cnt;
   int                   last_served;
   logic [31:0]          lfsr_q;
   wb_req_t              rand_req [NUM_MASTERS][NUM_RAND];

   wb_interconnect_top i_wb_interconnect_top (
      .clk_i    (clk_i),
      .rst_n    (rst_n),
      .m0_req_i (req[0]),
      .m0_rsp_o (rsp[0]),
      .m1_req_i (req[1]),
      .m1_rsp_o (rsp[1])
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic wb_req_t make_req(input logic [31:0] adr, input logic [31:0] dat,
                                        input logic [3:0] sel, input logic we);
      wb_req_t r;
      r = '0;
      r.adr = adr;
      r.dat = dat;
      r.sel = sel;
      r.we  = we;
      return r;
   endfunction

   // Fill value mixes every address bit
   function automatic logic [31:0] fill_word(input logic [31:0] adr);
      return (adr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
   endfunction

   // Expected response
   // In-range writes update the model byte by byte
   function automatic wb_rsp_t ref_access(input wb_req_t r);
      wb_rsp_t     e;
      int unsigned idx;
      e   = '0;
      idx = (r.adr / 4) % SRAM_DEPTH;
      if (r.adr >= 32'(SRAM_DEPTH * 4)) begin
         e.err = 1'b1;
      end else begin
         e.ack = 1'b1;
         for (int b = 0; b < WB_SEL_W; b++) begin
            if (r.we && r.sel[b]) begin
               model_mem[idx][8*b +: 8] = r.dat[8*b +: 8];
            end
         end
         if (!r.we) begin
            e.dat = model_mem[idx];
         end
      end
      return e;
   endfunction

   task automatic value_error(input string msg);
      $display("ERROR @%0t: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "Wrong value");
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Run aborted");
   endtask

   ////////////////////////////////////////
   // Master driver
   ////////////////////////////////////////

   // lat > 0 also checks the number of cycles to ack or err
   task automatic issue(input int m, input wb_req_t r, input int lat);
      int n;
      exp_rsp[m] = ref_access(r);
      pending[m] = 1'b1;
      r.cyc  = 1'b1;
      r.stb  = 1'b1;
      req[m] = r;
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
         if (n > ACK_TIMEOUT) begin
            abort_run($sformatf("Master %0d never got ack or err after %0d cycles",
                                m, ACK_TIMEOUT));
         end
      end while (!(rsp[m].ack || rsp[m].err));
      // Drop the strobe for at least one cycle
      req[m]      = '0;
      done_cyc[m] = cyc_cnt;
      last_served = m;
      if (lat > 0) begin
         assert (n == lat)
         else value_error($sformatf("master %0d latency %0d, expected %0d", m, n, lat));
      end
      @(negedge clk_i);
   endtask

   task automatic check_order(input int first);
      assert (done_cyc[first] < done_cyc[1 - first])
      else value_error($sformatf("master %0d was not served first", first));
   endtask

   ////////////////////////////////////////
   // Comparing process
   ////////////////////////////////////////

   always @(negedge clk_i) begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
         if (rst_n && (rsp[m].ack || rsp[m].err)) begin
            assert (pending[m])
            else value_error($sformatf("master %0d response with no request", m));
            assert (rsp[m] == exp_rsp[m])
            else value_error($sformatf("master %0d got dat %h ack %b err %b, exp %h %b %b",
                                       m, rsp[m].dat, rsp[m].ack, rsp[m].err,
                                       exp_rsp[m].dat, exp_rsp[m].ack, exp_rsp[m].err));
            pending[m] = 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      logic [31:0] a;
      logic [31:0] d;
      logic [3:0]  s;
      logic        w;
      int          first;
      clk_i       = 1'b0;
      rst_n       = 1'b0;
      cyc_cnt     = 0;
      lfsr_q      = SEED;
      // Round robin starts as if the last master was served
      last_served = NUM_MASTERS - 1;
      for (int m = 0; m < NUM_MASTERS; m++) begin
         req[m]     = '0;
         exp_rsp[m] = '0;
         pending[m] = 1'b0;
      end
      repeat (RST_CYCLES) @(negedge clk_i);
      rst_n = 1'b1;
      // Idle responses stay zero
      repeat (2) begin
         @(negedge clk_i);
         assert (rsp[0] == '0 && rsp[1] == '0)
         else value_error("response not zero after reset");
      end

      // Simultaneous strobes, then one uncontended access each
      first = (last_served + 1) % NUM_MASTERS;
      fork
         issue(0, make_req(32'h010, 32'h1111_0000, 4'hf, 1'b1), 0);
         issue(1, make_req(32'h210, 32'h2222_0001, 4'hf, 1'b1), 0);
      join
      check_order(first);
      issue(1, make_req(32'h210, 32'h0, 4'hf, 1'b0), 4);
      issue(0, make_req(32'h010, 32'h0, 4'hf, 1'b0), 4);
      first = (last_served + 1) % NUM_MASTERS;
      fork
         issue(0, make_req(32'h010, 32'h0, 4'hf, 1'b0), 0);
         issue(1, make_req(32'h210, 32'h0, 4'hf, 1'b0), 0);
      join
      check_order(first);

      // Fill both halves concurrently so no read returns unknown data
      fork
         for (int k = 0; k < HALF_WORDS; k++) begin
            issue(0, make_req(32'(4 * k), fill_word(32'(4 * k)), 4'hf, 1'b1), 0);
         end
         for (int k = HALF_WORDS; k < SRAM_DEPTH; k++) begin
            issue(1, make_req(32'(4 * k), fill_word(32'(4 * k)), 4'hf, 1'b1), 0);
         end
      join

      // Full words, then mixed byte selects, each read back
      for (int m = 0; m < NUM_MASTERS; m++) begin
         for (int k = 0; k < 24; k++) begin
            a = 32'(m * HALF_WORDS * 4 + 64 + 4 * (k % 8));
            d = rand_bits(32);
            s = (k < 8) ? 4'hf : 4'(rand_bits(4));
            issue(m, make_req(a, d, s, 1'b1), 4);
            issue(m, make_req(a, 32'h0, 4'hf, 1'b0), 4);
         end
      end

      // Outside the window, then the aliased word must be unchanged
      for (int k = 0; k < 4; k++) begin
         a = 32'h400 + 32'(4 * k);
         issue(0, make_req(a, 32'hdead_beef, 4'hf, 1'b1), 4);
         issue(0, make_req(a, 32'h0, 4'hf, 1'b0), 4);
         issue(0, make_req(32'(4 * k), 32'h0, 4'hf, 1'b0), 4);
      end
      issue(1, make_req(32'hffff_fffc, 32'h0, 4'hf, 1'b0), 4);

      // Random traffic on disjoint halves
      for (int m = 0; m < NUM_MASTERS; m++) begin
         for (int i = 0; i < NUM_RAND; i++) begin
            a = 32'((m * HALF_WORDS + int'(rand_bits(7))) * 4);
            // About one access in sixteen leaves the window
            if (rand_bits(4) == 0) begin
               a = a + 32'h400;
            end
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            w = rand_bits(1) == 1;
            rand_req[m][i] = make_req(a, d, s, w);
         end
      end
      fork
         for (int i = 0; i < NUM_RAND; i++) begin
            issue(0, rand_req[0][i], 0);
         end
         for (int i = 0; i < NUM_RAND; i++) begin
            issue(1, rand_req[1][i], 0);
         end
      join

      if (i_wb_interconnect_top.i_checker.fail_cnt == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("Protocol checker saw %0d failed assertions",
                  i_wb_interconnect_top.i_checker.fail_cnt);
         $display("TEST FAIL");
         $fatal(1, "Protocol assertions failed");
      end
   end

endmodule : tb_wb_interconnect

`default_nettype wire

//--- dv/wb_interconnect_checker.sv
// Wishbone master port checker
`timescale 1ns/1ps
`default_nettype none

// Watches both master ports of the interconnect top
module wb_interconnect_checker (
   input logic            clk_i,
   input logic            rst_n,
   input wb_pkg::wb_req_t m0_req_i,
   input wb_pkg::wb_rsp_t m0_rsp_o,
   input wb_pkg::wb_req_t m1_req_i,
   input wb_pkg::wb_rsp_t m1_rsp_o
);

   // Number of failed assertions
   int unsigned fail_cnt = 0;

   logic m0_done;
   logic m1_done;

   assign m0_done = m0_rsp_o.ack | m0_rsp_o.err;
   assign m1_done = m1_rsp_o.ack | m1_rsp_o.err;

   ////////////////////////////////////////
   // Master 0
   ////////////////////////////////////////

   // Never ack and err together
   a_m0_excl: assert property (@(posedge clk_i) disable iff (!rst_n)
      !(m0_rsp_o.ack && m0_rsp_o.err))
   else begin
      $error("master 0 ack and err together");
      fail_cnt++;
   end

   // One-cycle pulse
   a_m0_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
      m0_done |=> !m0_done)
   else begin
      $error("master 0 response longer than one cycle");
      fail_cnt++;
   end

   // Strobe was up the cycle before
   a_m0_stb: assert property (@(posedge clk_i) disable iff (!rst_n)
      m0_done |-> $past(m0_req_i.stb))
   else begin
      $error("master 0 response without strobe");
      fail_cnt++;
   end

   ////////////////////////////////////////
   // Master 1
   ////////////////////////////////////////

   a_m1_excl: assert property (@(posedge clk_i) disable iff (!rst_n)
      !(m1_rsp_o.ack && m1_rsp_o.err))
   else begin
      $error("master 1 ack and err together");
      fail_cnt++;
   end

   a_m1_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
      m1_done |=> !m1_done)
   else begin
      $error("master 1 response longer than one cycle");
      fail_cnt++;
   end

   a_m1_stb: assert property (@(posedge clk_i) disable iff (!rst_n)
      m1_done |-> $past(m1_req_i.stb))
   else begin
      $error("master 1 response without strobe");
      fail_cnt++;
   end

endmodule : wb_interconnect_checker

bind wb_interconnect_top wb_interconnect_checker i_checker (
   .clk_i    (clk_i),
   .rst_n    (rst_n),
   .m0_req_i (m0_req_i),
   .m0_rsp_o (m0_rsp_o),
   .m1_req_i (m1_req_i),
   .m1_rsp_o (m1_rsp_o)
);

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Wishbone interconnect simulation with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_wb_interconnect
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
   -f wb_interconnect.f \
   --top-module "$TOP" \
   --Mdir "$BUILD_DIR" \
   -o sim_"$TOP"
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

# Let assertion errors reach the testbench's final report
"./$BUILD_DIR/sim_$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
fi

if grep -qx "TEST PASS" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

//--- verilog/wb_arbiter.sv
// Round-robin Wishbone arbiter
`timescale 1ns/1ps
`default_nettype none

// Grants one staged master the shared slave bus at a time
// Grant is registered, request mux and response routing are combinational
module wb_arbiter (
   input  logic                                      clk_i,
   input  logic                                      rst_n,
   // Staged master requests and their responses
   input  wb_pkg::wb_req_t [wb_pkg::NUM_MASTERS-1:0] req_i,
   output wb_pkg::wb_rsp_t [wb_pkg::NUM_MASTERS-1:0] rsp_o,
   // Shared slave bus
   output wb_pkg::wb_req_t                           bus_req_o,
   input  wb_pkg::wb_rsp_t                           bus_rsp_i
);

   import wb_pkg::*;

   // A transfer owns the bus
   logic                 busy_q;
   // Index of the master holding the bus
   logic [MST_IDX_W-1:0] gnt_q;
   // Master served most recently, start point of the rotation
   logic [MST_IDX_W-1:0] last_q;
   // Round-robin pick for the current cycle
   logic                 win_vld;
   logic [MST_IDX_W-1:0] win_idx;
   // Slave ends the granted transfer
   logic                 bus_done;

   assign bus_done = bus_rsp_i.ack | bus_rsp_i.err;

   ////////////////////////////////////////
   // Round-robin pick
   ////////////////////////////////////////

   // Walk from the farthest candidate back to the one right after last_q
   // so the nearest requester in rotation order overwrites the rest
   always_comb begin
      int unsigned cand;
      win_vld = 1'b0;
      win_idx = '0;
      for (int k = NUM_MASTERS; k >= 1; k--) begin
         cand = (int'(last_q) + k) % NUM_MASTERS;
         if (req_i[cand].cyc && req_i[cand].stb) begin
            win_vld = 1'b1;
            win_idx = MST_IDX_W'(cand);
         end
      end
   end

   ////////////////////////////////////////
   // Grant register
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         gnt_q  <= '0;
         // Pointing at the last master makes master 0 first after reset
         last_q <= MST_IDX_W'(NUM_MASTERS - 1);
      end else if (!busy_q) begin
         if (win_vld) begin
            busy_q <= 1'b1;
            gnt_q  <= win_idx;
            last_q <= win_idx;
         end
      end else if (bus_done) begin
         // Release on the acknowledge edge, the bus idles one cycle
         busy_q <= 1'b0;
         gnt_q  <= '0;
      end
   end

   ////////////////////////////////////////
   // Bus mux and response routing
   ////////////////////////////////////////

   // Idle bus carries an all-zero request
   assign bus_req_o = busy_q ? req_i[gnt_q] : '0;

   // Only the granted master sees ack, err and data
   always_comb begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
         if (busy_q && (gnt_q == MST_IDX_W'(m))) begin
            rsp_o[m] = bus_rsp_i;
         end else begin
            rsp_o[m] = '0;
         end
      end
   end

endmodule : wb_arbiter

`default_nettype wire

//--- verilog/wb_interconnect_top.sv
// Two-master Wishbone interconnect
`timescale 1ns/1ps
`default_nettype none

// Master ports -> staging flops -> round-robin arbiter -> SRAM slave
// Uncontended path: ack or err reaches the master four cycles after strobe
module wb_interconnect_top (
   input  logic            clk_i,
   input  logic            rst_n,
   // Master 0
   input  wb_pkg::wb_req_t m0_req_i,
   output wb_pkg::wb_rsp_t m0_rsp_o,
   // Master 1
   input  wb_pkg::wb_req_t m1_req_i,
   output wb_pkg::wb_rsp_t m1_rsp_o
);

   import wb_pkg::*;

   ////////////////////////////////////////
   // Internal links
   ////////////////////////////////////////

   // Staging blocks to arbiter
   wb_req_t [NUM_MASTERS-1:0] stg_req;
   wb_rsp_t [NUM_MASTERS-1:0] stg_rsp;
   // Arbiter to SRAM
   wb_req_t                   bus_req;
   wb_rsp_t                   bus_rsp;

   // Master 0 staging
   wb_stagging i_stg_m0 (
      .clk_i   (clk_i),
      .rst_n   (rst_n),
      .m_req_i (m0_req_i),
      .m_rsp_o (m0_rsp_o),
      .s_req_o (stg_req[0]),
      .s_rsp_i (stg_rsp[0])
   );

   // Master 1 staging
   wb_stagging i_stg_m1 (
      .clk_i   (clk_i),
      .rst_n   (rst_n),
      .m_req_i (m1_req_i),
      .m_rsp_o (m1_rsp_o),
      .s_req_o (stg_req[1]),
      .s_rsp_i (stg_rsp[1])
   );

   wb_arbiter i_arbiter (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .req_i     (stg_req),
      .rsp_o     (stg_rsp),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   // Single shared slave
   wb_sram i_sram (
      .clk_i (clk_i),
      .rst_n (rst_n),
      .req_i (bus_req),
      .rsp_o (bus_rsp)
   );

endmodule : wb_interconnect_top

`default_nettype wire

//--- verilog/wb_pkg.sv
// Wishbone fabric definitions
`default_nettype none

package wb_pkg;

   ////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////

   // Data path width in bits
   localparam int WB_DATA_W = 32;
   // Byte address width
   localparam int WB_ADDR_W = 32;
   // One select bit per data byte
   localparam int WB_SEL_W = WB_DATA_W / 8;

   ////////////////////////////////////////
   // Slave memory and fabric size
   ////////////////////////////////////////

   // SRAM depth in 32-bit words, byte window 0 .. 1023
   localparam int SRAM_DEPTH = 256;
   // Word index width
   localparam int SRAM_AW = $clog2(SRAM_DEPTH);

   // Peer masters sharing the slave bus
   localparam int NUM_MASTERS = 2;
   // Width of a master index (grant, last served)
   localparam int MST_IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

   ////////////////////////////////////////
   // Request and response payloads
   ////////////////////////////////////////

   // Master to slave, 71 bits
   typedef struct packed {
      logic [WB_DATA_W-1:0] dat;  // write data
      logic [WB_ADDR_W-1:0] adr;  // byte address
      logic [WB_SEL_W-1:0]  sel;
      logic                 we;
      logic                 cyc;
      logic                 stb;
   } wb_req_t;

   // Slave to master, 34 bits
   // ack and err are one-cycle pulses, never together
   typedef struct packed {
      logic [WB_DATA_W-1:0] dat;  // read data
      logic                 ack;
      logic                 err;
   } wb_rsp_t;

endpackage : wb_pkg

`default_nettype wire

//--- verilog/wb_sram.sv
// Wishbone SRAM slave
`timescale 1ns/1ps
`default_nettype none

// Word-addressed on-chip memory with byte selects
// Answers outside the 1 KiB window with err and zero data
module wb_sram (
   input  logic            clk_i,
   input  logic            rst_n,
   input  wb_pkg::wb_req_t req_i,
   output wb_pkg::wb_rsp_t rsp_o
);

   import wb_pkg::*;

   // Storage array
   logic [WB_DATA_W-1:0] mem_q [SRAM_DEPTH];

   // Word index taken from the byte address
   logic [SRAM_AW-1:0]   word_idx;
   // Address falls inside the window
   logic                 in_range;
   // New strobe while no response is pending
   logic                 req_vld;

   // Registered response
   logic                 ack_q;
   logic                 err_q;
   logic [WB_DATA_W-1:0] rdat_q;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   assign word_idx = req_i.adr[SRAM_AW+1:2];

   // All bits above the word index must be zero
   assign in_range = (req_i.adr[WB_ADDR_W-1:SRAM_AW+2] == '0);

   // Strobe is still high in the ack cycle, mask it to keep the pulse single
   assign req_vld = req_i.cyc & req_i.stb & ~ack_q & ~err_q;

   ////////////////////////////////////////
   // Memory write
   ////////////////////////////////////////

   // Only selected byte lanes change
   // Out-of-range writes are dropped
   always_ff @(posedge clk_i) begin
      if (req_vld && in_range && req_i.we) begin
         for (int b = 0; b < WB_SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem_q[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////
   // Response
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
         rdat_q <= '0;
      end else begin
         ack_q <= req_vld & in_range;
         err_q <= req_vld & ~in_range;
         // Data is valid only alongside ack of a read, zero otherwise
         if (req_vld && in_range && !req_i.we) begin
            rdat_q <= mem_q[word_idx];
         end else begin
            rdat_q <= '0;
         end
      end
   end

   assign rsp_o.dat = rdat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = err_q;

endmodule : wb_sram

`default_nettype wire

//--- verilog/wb_stagging.sv
// Wishbone staging register
`timescale 1ns/1ps
`default_nettype none

// Holding flops between one master and the interconnect
// Both directions are registered so the fabric sees a flop on each side
// Costs one idle cycle between back-to-back transactions
module wb_stagging (
   input  logic            clk_i,
   input  logic            rst_n,
   // Master side
   input  wb_pkg::wb_req_t m_req_i,
   output wb_pkg::wb_rsp_t m_rsp_o,
   // Interconnect side
   output wb_pkg::wb_req_t s_req_o,
   input  wb_pkg::wb_rsp_t s_rsp_i
);

   import wb_pkg::*;

   // Holding register is occupied
   logic    busy_q;
   // Captured master request
   wb_req_t req_q;
   // Response delayed by one cycle toward the master
   wb_rsp_t rsp_q;
   // Slave side finished the staged transfer
   logic    slv_done;
   // Load a new request this cycle
   logic    take_req;

   assign slv_done = s_rsp_i.ack | s_rsp_i.err;

   // Only free when nothing is held and no response is still in flight
   // toward the master, otherwise the same strobe would be taken twice
   assign take_req = m_req_i.stb & ~busy_q & ~rsp_q.ack & ~rsp_q.err;

   ////////////////////////////////////////
   // Request path
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         req_q  <= '0;
      end else if (take_req) begin
         busy_q <= 1'b1;
         req_q  <= m_req_i;
      end else if (busy_q && slv_done) begin
         // Drop cyc/stb and payload together once the slave answers
         busy_q <= 1'b0;
         req_q  <= '0;
      end
   end

   ////////////////////////////////////////
   // Response path
   ////////////////////////////////////////

   // Flopped every cycle, no qualification
   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         rsp_q <= '0;
      end else begin
         rsp_q <= s_rsp_i;
      end
   end

   assign s_req_o = req_q;
   assign m_rsp_o = rsp_q;

endmodule : wb_stagging

`default_nettype wire

//--- wb_interconnect.f
verilog/wb_pkg.sv
verilog/wb_stagging.sv
verilog/wb_arbiter.sv
verilog/wb_sram.sv
verilog/wb_interconnect_top.sv
dv/wb_interconnect_checker.sv
dv/tb_wb_interconnect.sv
